// File: hw/dispatchPkg.sv
// --------------------------------------------------------------------
// Shared sizes, field widths and packet types of the dispatch stage.
// Import it into every dispatch module that uses a packet struct.
// --------------------------------------------------------------------
package dispatchPkg;

  // Default machine sizes handed down as module parameters from the top
  localparam int DefDispatchWidth  = 4;   // Lanes per group
  localparam int DefCheckpoints    = 8;   // Branch checkpoints and mask width
  localparam int DefLsqSize        = 16;  // Load queue and store queue each
  localparam int DefIssueqSize     = 32;
  localparam int DefActiveListSize = 64;

  // Fixed field widths
  localparam int PcWidth        = 32;
  localparam int OpcodeWidth    = 8;
  localparam int ImmWidth       = 16;
  localparam int PhyRegLog      = 7;   // Physical register tag
  localparam int LogRegLog      = 5;   // Architectural register index
  localparam int CheckpointsLog = $clog2(DefCheckpoints);

  // One lane as it leaves rename
  typedef struct packed {
    logic [PcWidth-1:0]        pc;
    logic [OpcodeWidth-1:0]    opcode;
    logic [ImmWidth-1:0]       imm;
    logic [PhyRegLog-1:0]      srcTag1;
    logic [PhyRegLog-1:0]      srcTag2;
    logic [PhyRegLog-1:0]      destTag;
    logic [PhyRegLog-1:0]      oldDestTag;    // Freed when the lane retires
    logic [LogRegLog-1:0]      logDest;
    logic                      isLoad;
    logic                      isStore;
    logic [DefCheckpoints-1:0] branchMask;    // Unresolved branches it depends on
    logic [CheckpointsLog-1:0] ckptId;
  } renamedPkt_t;

  // Issue queue entry
  typedef struct packed {
    logic [PcWidth-1:0]        pc;
    logic [OpcodeWidth-1:0]    opcode;
    logic [ImmWidth-1:0]       imm;
    logic [PhyRegLog-1:0]      srcTag1;
    logic [PhyRegLog-1:0]      srcTag2;
    logic [PhyRegLog-1:0]      destTag;
    logic                      isLoad;
    logic                      isStore;
    logic [DefCheckpoints-1:0] branchMask;    // Already updated for a verified branch
    logic [CheckpointsLog-1:0] ckptId;
  } iqPkt_t;

  // Active list entry with only what retirement needs
  typedef struct packed {
    logic                 isLoad;
    logic                 isStore;
    logic [PcWidth-1:0]   pc;
    logic [LogRegLog-1:0] logDest;
    logic [PhyRegLog-1:0] destTag;
    logic [PhyRegLog-1:0] oldDestTag;
  } alPkt_t;

  // Load-store queue entry
  typedef struct packed {
    logic [DefCheckpoints-1:0] branchMask;
    logic                      isStore;
    logic                      isLoad;
  } lsqPkt_t;

endpackage

// File: hw/dispatchIf.sv
// --------------------------------------------------------------------
// Links the capacity check and the packet former to the dispatch latch.
// Carries accept/hold and the per-lane back-end packets.
// --------------------------------------------------------------------
interface dispatchIf import dispatchPkg::*; #(
  parameter int DispatchWidth = DefDispatchWidth
);

  logic                         accept;  // Group enters the latch this cycle
  logic                         hold;    // Back end stalled, latch keeps content
  iqPkt_t  [DispatchWidth-1:0]  iqPkt;
  alPkt_t  [DispatchWidth-1:0]  alPkt;
  lsqPkt_t [DispatchWidth-1:0]  lsqPkt;

  // Capacity check side
  modport check (
    output accept,
    output hold
  );

  modport former (
    output iqPkt,
    output alPkt,
    output lsqPkt
  );

  modport latch (
    input accept,
    input hold,
    input iqPkt,
    input alPkt,
    input lsqPkt
  );

endinterface

// File: hw/capacityCheck.sv
// --------------------------------------------------------------------
// Room check for a dispatch group. Counts loads and stores, tests every
// back-end queue against its size and decides accept or hold.
// --------------------------------------------------------------------
module capacityCheck import dispatchPkg::*; #(
  parameter int DispatchWidth  = DefDispatchWidth,
  parameter int LsqSize        = DefLsqSize,
  parameter int IssueqSize     = DefIssueqSize,
  parameter int ActiveListSize = DefActiveListSize
) (
  input  renamedPkt_t [DispatchWidth-1:0]    renamedPacket_i,
  input  logic [$clog2(LsqSize):0]           loadQueueCnt_i,
  input  logic [$clog2(LsqSize):0]           storeQueueCnt_i,
  input  logic [$clog2(IssueqSize):0]        issueQueueCnt_i,
  input  logic [$clog2(ActiveListSize):0]    activeListCnt_i,
  input  logic                               renameReady_i,    // Rename holds a full group
  input  logic                               stall_i,          // Back-end back-pressure
  input  logic                               flagRecoverEX_i,  // Mispredict recovery
  output logic                               backEndReady_o,
  output logic                               stallFrontEnd_o,
  dispatchIf.check                           ctrl
);

  localparam int CntW = $clog2(DispatchWidth + 1);

  logic [CntW-1:0] loadCnt;
  logic [CntW-1:0] storeCnt;
  logic            lqNoRoom;
  logic            sqNoRoom;
  logic            iqNoRoom;
  logic            alNoRoom;
  logic            noRoom;

  // Loads and stores in the incoming group
  always_comb begin
    loadCnt  = '0;
    storeCnt = '0;
    for (int i = 0; i < DispatchWidth; i++) begin
      loadCnt  = loadCnt + CntW'(renamedPacket_i[i].isLoad);
      storeCnt = storeCnt + CntW'(renamedPacket_i[i].isStore);
    end
  end

  // Only memory ops take LSQ entries, every lane takes an IQ and AL entry
  assign lqNoRoom = (int'(loadQueueCnt_i) + int'(loadCnt)) > LsqSize;
  assign sqNoRoom = (int'(storeQueueCnt_i) + int'(storeCnt)) > LsqSize;
  assign iqNoRoom = (int'(issueQueueCnt_i) + DispatchWidth) > IssueqSize;
  assign alNoRoom = (int'(activeListCnt_i) + DispatchWidth) > ActiveListSize;

  assign noRoom = lqNoRoom | sqNoRoom | iqNoRoom | alNoRoom;

  assign stallFrontEnd_o = noRoom;
  assign backEndReady_o  = renameReady_i & ~noRoom & ~stall_i & ~flagRecoverEX_i;

  assign ctrl.accept = backEndReady_o;
  // A recovery overrides back-pressure and flushes the latch
  assign ctrl.hold   = stall_i & ~flagRecoverEX_i;

endmodule

// File: hw/packetFormer.sv
// --------------------------------------------------------------------
// Forms the back-end packets of each lane. Clears the bit of a branch
// verified this cycle from the mask, then splits the renamed fields.
// --------------------------------------------------------------------
module packetFormer import dispatchPkg::*; #(
  parameter int DispatchWidth = DefDispatchWidth,
  parameter int Checkpoints   = DefCheckpoints
) (
  input  renamedPkt_t [DispatchWidth-1:0]  renamedPacket_i,
  input  logic                             ctrlVerified_i,    // Branch resolved correctly
  input  logic [$clog2(Checkpoints)-1:0]   ctrlVerifiedId_i,  // Its checkpoint
  dispatchIf.former                        pkts
);

  logic [DispatchWidth-1:0][Checkpoints-1:0] newMask;

  // Drop the verified checkpoint from every lane's dependency mask
  always_comb begin
    for (int i = 0; i < DispatchWidth; i++) begin
      newMask[i] = renamedPacket_i[i].branchMask;
      for (int b = 0; b < Checkpoints; b++) begin
        if (ctrlVerified_i && (b == int'(ctrlVerifiedId_i))) begin
          newMask[i][b] = 1'b0;
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < DispatchWidth; i++) begin
      pkts.iqPkt[i].pc         = renamedPacket_i[i].pc;
      pkts.iqPkt[i].opcode     = renamedPacket_i[i].opcode;
      pkts.iqPkt[i].imm        = renamedPacket_i[i].imm;
      pkts.iqPkt[i].srcTag1    = renamedPacket_i[i].srcTag1;
      pkts.iqPkt[i].srcTag2    = renamedPacket_i[i].srcTag2;
      pkts.iqPkt[i].destTag    = renamedPacket_i[i].destTag;
      pkts.iqPkt[i].isLoad     = renamedPacket_i[i].isLoad;
      pkts.iqPkt[i].isStore    = renamedPacket_i[i].isStore;
      pkts.iqPkt[i].branchMask = newMask[i];
      pkts.iqPkt[i].ckptId     = renamedPacket_i[i].ckptId;

      // Retirement frees oldDestTag and updates the map for logDest
      pkts.alPkt[i].isLoad     = renamedPacket_i[i].isLoad;
      pkts.alPkt[i].isStore    = renamedPacket_i[i].isStore;
      pkts.alPkt[i].pc         = renamedPacket_i[i].pc;
      pkts.alPkt[i].logDest    = renamedPacket_i[i].logDest;
      pkts.alPkt[i].destTag    = renamedPacket_i[i].destTag;
      pkts.alPkt[i].oldDestTag = renamedPacket_i[i].oldDestTag;

      pkts.lsqPkt[i].branchMask = newMask[i];
      pkts.lsqPkt[i].isStore    = renamedPacket_i[i].isStore;
      pkts.lsqPkt[i].isLoad     = renamedPacket_i[i].isLoad;
    end
  end

endmodule

// File: hw/dispatchLatch.sv
// --------------------------------------------------------------------
// Pipeline register between dispatch and the back-end queues.
// Loads an accepted group, keeps it under back-pressure, else empties.
// --------------------------------------------------------------------
module dispatchLatch import dispatchPkg::*; #(
  parameter int DispatchWidth = DefDispatchWidth
) (
  input  logic                         clk,
  input  logic                         rst_i,
  dispatchIf.latch                     pkts,
  output iqPkt_t  [DispatchWidth-1:0]  issueqPacket_o,
  output alPkt_t  [DispatchWidth-1:0]  alPacket_o,
  output lsqPkt_t [DispatchWidth-1:0]  lsqPacket_o,
  output logic                         dispatchValid_o
);

  // Valid flag of the group in the latch
  always_ff @(posedge clk) begin
    if (rst_i) begin
      dispatchValid_o <= 1'b0;
    end else if (pkts.accept) begin
      dispatchValid_o <= 1'b1;
    end else if (!pkts.hold) begin
      dispatchValid_o <= 1'b0;  // Consumed by the back end or flushed
    end
  end

  // Packet payload only moves on accept
  always_ff @(posedge clk) begin
    if (pkts.accept) begin
      issueqPacket_o <= pkts.iqPkt;
      alPacket_o     <= pkts.alPkt;
      lsqPacket_o    <= pkts.lsqPkt;
    end
  end

endmodule

// File: hw/dispatchTop.sv
// --------------------------------------------------------------------
// Dispatch stage top level. Checks back-end room, forms the packets and
// registers the accepted group towards the issue queue, AL and LSQ.
// --------------------------------------------------------------------
module dispatchTop import dispatchPkg::*; #(
  parameter int DispatchWidth  = DefDispatchWidth,
  parameter int Checkpoints    = DefCheckpoints,
  parameter int LsqSize        = DefLsqSize,
  parameter int IssueqSize     = DefIssueqSize,
  parameter int ActiveListSize = DefActiveListSize
) (
  input  logic                             clk,
  input  logic                             rst_i,
  input  logic                             renameReady_i,
  input  logic                             stall_i,
  input  logic                             flagRecoverEX_i,
  input  logic                             ctrlVerified_i,
  input  logic [$clog2(Checkpoints)-1:0]   ctrlVerifiedId_i,
  input  renamedPkt_t [DispatchWidth-1:0]  renamedPacket_i,
  input  logic [$clog2(LsqSize):0]         loadQueueCnt_i,   // Occupancies of the queues
  input  logic [$clog2(LsqSize):0]         storeQueueCnt_i,
  input  logic [$clog2(IssueqSize):0]      issueQueueCnt_i,
  input  logic [$clog2(ActiveListSize):0]  activeListCnt_i,
  output iqPkt_t  [DispatchWidth-1:0]      issueqPacket_o,
  output alPkt_t  [DispatchWidth-1:0]      alPacket_o,
  output lsqPkt_t [DispatchWidth-1:0]      lsqPacket_o,
  output logic                             dispatchValid_o,
  output logic                             backEndReady_o,   // Rename may advance
  output logic                             stallFrontEnd_o
);

  dispatchIf #(.DispatchWidth(DispatchWidth)) dispIf ();

  capacityCheck #(
    .DispatchWidth  (DispatchWidth),
    .LsqSize        (LsqSize),
    .IssueqSize     (IssueqSize),
    .ActiveListSize (ActiveListSize)
  ) capacityCheck_i (
    .renamedPacket_i (renamedPacket_i),
    .loadQueueCnt_i  (loadQueueCnt_i),
    .storeQueueCnt_i (storeQueueCnt_i),
    .issueQueueCnt_i (issueQueueCnt_i),
    .activeListCnt_i (activeListCnt_i),
    .renameReady_i   (renameReady_i),
    .stall_i         (stall_i),
    .flagRecoverEX_i (flagRecoverEX_i),
    .backEndReady_o  (backEndReady_o),
    .stallFrontEnd_o (stallFrontEnd_o),
    .ctrl            (dispIf)
  );

  packetFormer #(
    .DispatchWidth (DispatchWidth),
    .Checkpoints   (Checkpoints)
  ) packetFormer_i (
    .renamedPacket_i  (renamedPacket_i),
    .ctrlVerified_i   (ctrlVerified_i),
    .ctrlVerifiedId_i (ctrlVerifiedId_i),
    .pkts             (dispIf)
  );

  dispatchLatch #(
    .DispatchWidth (DispatchWidth)
  ) dispatchLatch_i (
    .clk             (clk),
    .rst_i           (rst_i),
    .pkts            (dispIf),
    .issueqPacket_o  (issueqPacket_o),
    .alPacket_o      (alPacket_o),
    .lsqPacket_o     (lsqPacket_o),
    .dispatchValid_o (dispatchValid_o)
  );

endmodule

// File: testbench/dispatchTb.sv
// ----------------------------------------------------------------------
// Directed testbench for the dispatch stage. Drives groups on the falling
// edge, checks room decisions, packet split, masks, stall and recovery.
// ----------------------------------------------------------------------
module dispatchTb import dispatchPkg::*; ();

  localparam int DW             = DefDispatchWidth;
  localparam int CK             = DefCheckpoints;
  localparam int LsqSize        = DefLsqSize;
  localparam int IssueqSize     = DefIssueqSize;
  localparam int ActiveListSize = DefActiveListSize;
  localparam int LqCntW         = $clog2(LsqSize) + 1;
  localparam int IqCntW         = $clog2(IssueqSize) + 1;
  localparam int AlCntW         = $clog2(ActiveListSize) + 1;
  localparam int EdgeTimeout    = 8;              // Polls before a missing edge is fatal
  localparam int RandomRounds   = 48;
  localparam logic [31:0] LfsrSeed = 32'hb2f1_28ac;
  localparam logic [31:0] LfsrTaps = 32'hd000_0001;

  logic                        clk = 1'b0;
  logic                        rst_i;
  logic                        renameReady;
  logic                        stall;
  logic                        flagRecover;
  logic                        ctrlVerified;
  logic [CheckpointsLog-1:0]   ctrlVerifiedId;
  renamedPkt_t [DW-1:0]        renamedPacket;
  logic [LqCntW-1:0]           lqCnt;
  logic [LqCntW-1:0]           sqCnt;
  logic [IqCntW-1:0]           iqCnt;
  logic [AlCntW-1:0]           alCnt;
  iqPkt_t  [DW-1:0]            issueqPacket;
  alPkt_t  [DW-1:0]            alPacket;
  lsqPkt_t [DW-1:0]            lsqPacket;
  logic                        dispatchValid;
  logic                        backEndReady;
  logic                        stallFrontEnd;

  iqPkt_t  [DW-1:0]            expIq;             // Reference packets of the latched group
  alPkt_t  [DW-1:0]            expAl;
  lsqPkt_t [DW-1:0]            expLsq;
  logic [31:0]                 lfsrState;
  string                       curTest;
  int                          testCount;
  int                          checkCount;
  int                          errCount;
  int                          testErrStart;

  always #2 clk = ~clk;

  dispatchTop dispatchTop_i (
    .clk              (clk),
    .rst_i            (rst_i),
    .renameReady_i    (renameReady),
    .stall_i          (stall),
    .flagRecoverEX_i  (flagRecover),
    .ctrlVerified_i   (ctrlVerified),
    .ctrlVerifiedId_i (ctrlVerifiedId),
    .renamedPacket_i  (renamedPacket),
    .loadQueueCnt_i   (lqCnt),
    .storeQueueCnt_i  (sqCnt),
    .issueQueueCnt_i  (iqCnt),
    .activeListCnt_i  (alCnt),
    .issueqPacket_o   (issueqPacket),
    .alPacket_o       (alPacket),
    .lsqPacket_o      (lsqPacket),
    .dispatchValid_o  (dispatchValid),
    .backEndReady_o   (backEndReady),
    .stallFrontEnd_o  (stallFrontEnd)
  );

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ LfsrTaps;
    end else begin
      return s >> 1;
    end
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);
      r = {r[30:0], lfsrState[0]};
    end
    return r;
  endfunction

  function automatic renamedPkt_t randomLane();
    renamedPkt_t p;
    p.pc         = takeBits(PcWidth);
    p.opcode     = OpcodeWidth'(takeBits(OpcodeWidth));
    p.imm        = ImmWidth'(takeBits(ImmWidth));
    p.srcTag1    = PhyRegLog'(takeBits(PhyRegLog));
    p.srcTag2    = PhyRegLog'(takeBits(PhyRegLog));
    p.destTag    = PhyRegLog'(takeBits(PhyRegLog));
    p.oldDestTag = PhyRegLog'(takeBits(PhyRegLog));
    p.logDest    = LogRegLog'(takeBits(LogRegLog));
    p.isLoad     = takeBits(1) != 0;
    p.isStore    = takeBits(1) != 0;
    p.branchMask = CK'(takeBits(CK));
    p.ckptId     = CheckpointsLog'(takeBits(CheckpointsLog));
    return p;
  endfunction

  // Clock is sampled at odd times between its edges
  task automatic waitEdge(input logic level);
    logic prev;
    logic found;
    int   polls;
    prev  = clk;
    found = 1'b0;
    polls = 0;
    while (!found && polls < EdgeTimeout) begin
      #2;
      found = (clk == level) && (prev != level);
      prev  = clk;
      polls++;
    end
    if (!found) begin
      $display("Timeout: the clock edge did not come within %0d polls", polls);
      $display("RESULT: FAIL");
      $finish;
    end
  endtask

  task automatic checkVal(input string what, input logic [127:0] expected,
                          input logic [127:0] actual);
    checkCount++;
    if (expected !== actual) begin
      errCount++;
      $display("MISMATCH %s %s expected=%0h actual=%0h", curTest, what, expected, actual);
    end
  endtask

  task automatic startTest(input string name);
    curTest      = name;
    testErrStart = errCount;
    testCount++;
  endtask

  task automatic endTest();
    if (errCount == testErrStart) begin
      $display("%s: ok", curTest);
    end else begin
      $display("%s: %0d errors", curTest, errCount - testErrStart);
    end
  endtask

  // Inputs change after the falling edge and results are checked after the rising one
  task automatic driveCycle(input renamedPkt_t [DW-1:0] grp, input logic ready,
                            input logic stl, input logic recover, input logic verified,
                            input logic [CheckpointsLog-1:0] id,
                            input int lq, input int sq, input int iq, input int al);
    waitEdge(1'b0);
    renamedPacket  = grp;
    renameReady    = ready;
    stall          = stl;
    flagRecover    = recover;
    ctrlVerified   = verified;
    ctrlVerifiedId = id;
    lqCnt          = LqCntW'(lq);
    sqCnt          = LqCntW'(sq);
    iqCnt          = IqCntW'(iq);
    alCnt          = AlCntW'(al);
    waitEdge(1'b1);
  endtask

  // Reference split of a group into the three back-end packets
  task automatic formExpected(input renamedPkt_t [DW-1:0] grp, input logic verified,
                              input logic [CheckpointsLog-1:0] id);
    logic [CK-1:0] mask;
    for (int i = 0; i < DW; i++) begin
      mask = grp[i].branchMask;
      if (verified) begin
        mask[id] = 1'b0;
      end
      expIq[i].pc          = grp[i].pc;
      expIq[i].opcode      = grp[i].opcode;
      expIq[i].imm         = grp[i].imm;
      expIq[i].srcTag1     = grp[i].srcTag1;
      expIq[i].srcTag2     = grp[i].srcTag2;
      expIq[i].destTag     = grp[i].destTag;
      expIq[i].isLoad      = grp[i].isLoad;
      expIq[i].isStore     = grp[i].isStore;
      expIq[i].branchMask  = mask;
      expIq[i].ckptId      = grp[i].ckptId;
      expAl[i].isLoad      = grp[i].isLoad;
      expAl[i].isStore     = grp[i].isStore;
      expAl[i].pc          = grp[i].pc;
      expAl[i].logDest     = grp[i].logDest;
      expAl[i].destTag     = grp[i].destTag;
      expAl[i].oldDestTag  = grp[i].oldDestTag;
      expLsq[i].branchMask = mask;
      expLsq[i].isStore    = grp[i].isStore;
      expLsq[i].isLoad     = grp[i].isLoad;
    end
  endtask

  task automatic checkPackets();
    for (int i = 0; i < DW; i++) begin
      checkVal($sformatf("lane%0d iq", i), 128'(expIq[i]), 128'(issueqPacket[i]));
      checkVal($sformatf("lane%0d al", i), 128'(expAl[i]), 128'(alPacket[i]));
      checkVal($sformatf("lane%0d lsq", i), 128'(expLsq[i]), 128'(lsqPacket[i]));
    end
  endtask

  task automatic checkHandshake(input logic ready, input logic stallFe, input logic valid);
    checkVal("backEndReady", 128'(ready), 128'(backEndReady));
    checkVal("stallFrontEnd", 128'(stallFe), 128'(stallFrontEnd));
    checkVal("dispatchValid", 128'(valid), 128'(dispatchValid));
  endtask

  function automatic renamedPkt_t [DW-1:0] randomGroup();
    renamedPkt_t [DW-1:0] grp;
    for (int i = 0; i < DW; i++) begin
      grp[i] = randomLane();
    end
    return grp;
  endfunction

  task automatic testResetState();
    startTest("reset");
    checkVal("dispatchValid", 128'(1'b0), 128'(dispatchValid));
    driveCycle(randomGroup(), 1'b1, 1'b0, 1'b0, 1'b0, '0, 0, 0, 0, 0);
    checkVal("backEndReady", 128'(1'b1), 128'(backEndReady));
    checkVal("stallFrontEnd", 128'(1'b0), 128'(stallFrontEnd));
    endTest();
  endtask

  task automatic testPacketSplit();
    renamedPkt_t [DW-1:0] grp;
    startTest("packetSplit");
    for (int r = 0; r < 4; r++) begin
      grp = randomGroup();
      formExpected(grp, 1'b0, '0);
      driveCycle(grp, 1'b1, 1'b0, 1'b0, 1'b0, '0, 3, 5, 10, 20);
      checkHandshake(1'b1, 1'b0, 1'b1);
      checkPackets();
    end
    endTest();
  endtask

  // Lanes 0 to 2 load, lane 3 stores
  task automatic capacityCase(input int lq, input int sq, input int iq, input int al,
                              input logic full);
    renamedPkt_t [DW-1:0] grp;
    grp = randomGroup();
    for (int i = 0; i < DW; i++) begin
      grp[i].isLoad  = (i < 3);
      grp[i].isStore = (i >= 3);
    end
    driveCycle(grp, 1'b1, 1'b0, 1'b0, 1'b0, '0, lq, sq, iq, al);
    checkHandshake(!full, full, !full);
  endtask

  task automatic testCapacity();
    startTest("capacity");
    capacityCase(LsqSize - 2, 0, 0, 0, 1'b1);
    capacityCase(LsqSize - 3, 0, 0, 0, 1'b0);            // Exactly full after the group
    capacityCase(0, LsqSize, 0, 0, 1'b1);
    capacityCase(0, LsqSize - 1, 0, 0, 1'b0);
    capacityCase(0, 0, IssueqSize - DW + 1, 0, 1'b1);
    capacityCase(0, 0, IssueqSize - DW, 0, 1'b0);
    capacityCase(0, 0, 0, ActiveListSize - DW + 1, 1'b1);
    capacityCase(0, 0, 0, ActiveListSize - DW, 1'b0);
    endTest();
  endtask

  task automatic testBranchMask();
    renamedPkt_t [DW-1:0]      grp;
    logic [CheckpointsLog-1:0] id;
    startTest("branchMask");
    for (int r = 0; r < 4; r++) begin
      grp = randomGroup();
      grp[0].branchMask = '1;
      id = CheckpointsLog'(takeBits(CheckpointsLog));
      formExpected(grp, 1'b1, id);
      driveCycle(grp, 1'b1, 1'b0, 1'b0, 1'b1, id, 0, 0, 0, 0);
      checkHandshake(1'b1, 1'b0, 1'b1);
      checkPackets();
      for (int i = 0; i < DW; i++) begin
        checkVal("iq mask bit", 128'(1'b0), 128'(issueqPacket[i].branchMask[id]));
        checkVal("lsq mask bit", 128'(1'b0), 128'(lsqPacket[i].branchMask[id]));
      end
    end
    endTest();
  endtask

  task automatic testStallRecover();
    renamedPkt_t [DW-1:0] grp;
    startTest("stallRecover");
    grp = randomGroup();
    formExpected(grp, 1'b0, '0);
    driveCycle(grp, 1'b1, 1'b0, 1'b0, 1'b0, '0, 0, 0, 0, 0);
    checkHandshake(1'b1, 1'b0, 1'b1);
    for (int r = 0; r < 3; r++) begin
      driveCycle(randomGroup(), 1'b1, 1'b1, 1'b0, 1'b0, '0, 0, 0, 0, 0);
      checkHandshake(1'b0, 1'b0, 1'b1);                   // Old group stays in the latch
      checkPackets();
    end
    driveCycle(randomGroup(), 1'b1, 1'b1, 1'b1, 1'b0, '0, 0, 0, 0, 0);
    checkHandshake(1'b0, 1'b0, 1'b0);
    endTest();
  endtask

  task automatic testRandom();
    renamedPkt_t [DW-1:0]      grp;
    logic                      ready;
    logic                      stl;
    logic                      recover;
    logic                      verified;
    logic [CheckpointsLog-1:0] id;
    logic                      noRoom;
    logic                      expReady;
    logic                      expValid;
    int                        lq;
    int                        sq;
    int                        iq;
    int                        al;
    int                        loads;
    int                        stores;
    startTest("random");
    expValid = 1'b0;                                      // Latch was flushed before
    for (int r = 0; r < RandomRounds; r++) begin
      grp      = randomGroup();
      ready    = takeBits(3) != 0;
      stl      = takeBits(2) == 0;
      recover  = takeBits(3) == 0;
      verified = takeBits(1) != 0;
      id       = CheckpointsLog'(takeBits(CheckpointsLog));
      lq       = int'(takeBits(5)) % (LsqSize + 1);
      sq       = int'(takeBits(5)) % (LsqSize + 1);
      iq       = int'(takeBits(6)) % (IssueqSize + 1);
      al       = int'(takeBits(7)) % (ActiveListSize + 1);
      loads    = 0;
      stores   = 0;
      for (int i = 0; i < DW; i++) begin
        loads  += int'(grp[i].isLoad);
        stores += int'(grp[i].isStore);
      end
      noRoom = (lq + loads > LsqSize) || (sq + stores > LsqSize) ||
               (iq + DW > IssueqSize) || (al + DW > ActiveListSize);
      expReady = ready && !noRoom && !stl && !recover;
      if (expReady) begin
        expValid = 1'b1;
        formExpected(grp, verified, id);
      end else if (!(stl && !recover)) begin
        expValid = 1'b0;
      end
      driveCycle(grp, ready, stl, recover, verified, id, lq, sq, iq, al);
      checkHandshake(expReady, noRoom, expValid);
      if (expValid) begin
        checkPackets();
      end
    end
    endTest();
  endtask

  initial begin
    rst_i          = 1'b1;
    renameReady    = 1'b0;
    stall          = 1'b0;
    flagRecover    = 1'b0;
    ctrlVerified   = 1'b0;
    ctrlVerifiedId = '0;
    renamedPacket  = '0;
    lqCnt          = '0;
    sqCnt          = '0;
    iqCnt          = '0;
    alCnt          = '0;
    lfsrState      = LfsrSeed;
    testCount      = 0;
    checkCount     = 0;
    errCount       = 0;
    #1;                                                   // Move off the clock edges
    for (int i = 0; i < 5; i++) begin
      waitEdge(1'b1);
    end
    waitEdge(1'b0);
    rst_i = 1'b0;
    testResetState();
    testPacketSplit();
    testCapacity();
    testBranchMask();
    testStallRecover();
    testRandom();
    $display("tests=%0d checks=%0d errors=%0d", testCount, checkCount, errCount);
    if (errCount == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: dispatchTop.f
hw/dispatchPkg.sv
hw/dispatchIf.sv
hw/capacityCheck.sv
hw/packetFormer.sv
hw/dispatchLatch.sv
hw/dispatchTop.sv
testbench/dispatchTb.sv

// File: run.sh
#!/bin/sh
# Builds the dispatch testbench with Verilator and runs it.
# Exits non-zero unless the simulation reports a pass.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module dispatchTb -Mdir obj_dir -f dispatchTop.f

simOut=$(./obj_dir/VdispatchTb)
printf '%s\n' "$simOut"

printf '%s\n' "$simOut" | grep -qx 'RESULT: PASS'
